//--- design/bcrypt_pkg.sv
package bcrypt_pkg;

	// an expanded-key word and a P-array word share this width
	typedef logic [31:0] word_t;

	// one byte of the host key
	typedef logic [7:0] key_byte_t;

	// index into the P-array, 0 to 17
	typedef logic [4:0] p_addr_t;

	localparam int P_WORDS = 18;

	//////////////////////////////
	// blowfish P-array
	//////////////////////////////

	// initial P-array, taken from the fractional hex digits of pi
	localparam word_t P_INIT [P_WORDS] = '{
		32'h243f6a88, 32'h85a308d3, 32'h13198a2e, 32'h03707344,
		32'ha4093822, 32'h299f31d0, 32'h082efa98, 32'hec4e6c89,
		32'h452821e6, 32'h38d01377, 32'hbe5466cf, 32'h34e90c6c,
		32'hc0ac29b7, 32'hc97c50dd, 32'h3f84d5b5, 32'hb5470917,
		32'h9216d5d9, 32'h8979fb1b
	};

	//////////////////////////////
	// expander FSM
	//////////////////////////////

	// every key byte passes through wait1, wait2 and input.
	// output holds a finished word until it is read
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WAIT1,
		ST_WAIT2,
		ST_INPUT,
		ST_OUTPUT,
		ST_READ_SRC
	} expand_state_t;

endpackage

//--- design/bcrypt_key_regs.sv
`timescale 1ns/1ps

module bcrypt_key_regs #(
	parameter int KEY_LEN = 72
) (
	input  logic                       CLK,
	input  logic                       arst_n,
	input  logic                       key_wr,
	input  logic [$clog2(KEY_LEN)-1:0] key_addr,
	input  bcrypt_pkg::key_byte_t      key_byte,
	input  logic                       mode_wr,
	input  logic                       mode,
	input  logic                       start,
	output logic [8*KEY_LEN-1:0]       key,
	output logic                       sign_extension_bug,
	output logic                       data_valid,
	input  logic                       src_done,
	output logic                       busy
);

	localparam int ADDR_W = $clog2(KEY_LEN);
	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(KEY_LEN - 1);

	logic key_we;
	logic mode_we;
	logic start_ok;

	//////////////////////////////
	// host access
	//////////////////////////////

	// the expander reads the key straight from these registers,
	// so nothing may change under it while a run is in flight
	assign key_we   = key_wr && !busy && (key_addr <= LAST_ADDR);
	assign mode_we  = mode_wr && !busy;
	assign start_ok = start && !busy;

	// byte i sits at bits 8i+7 down to 8i
	always_ff @(posedge CLK) begin
		if (key_we) begin
			key[8*key_addr +: 8] <= key_byte;
		end
	end

	//////////////////////////////
	// run control
	//////////////////////////////

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			sign_extension_bug <= 1'b0;
			data_valid         <= 1'b0;
			busy               <= 1'b0;
		end else begin
			// one-cycle kick to the expander per accepted start
			data_valid <= start_ok;

			if (mode_we) begin
				sign_extension_bug <= mode;
			end

			// src_done arrives once the last word has left the expander
			if (start_ok) begin
				busy <= 1'b1;
			end else if (src_done) begin
				busy <= 1'b0;
			end
		end
	end

endmodule

//--- design/bcrypt_expand_key.sv
`timescale 1ns/1ps

module bcrypt_expand_key #(
	parameter int KEY_LEN = 72
) (
	input  logic                 CLK,
	input  logic                 arst_n,
	input  logic [8*KEY_LEN-1:0] din,
	input  logic                 data_valid,
	input  logic                 sign_extension_bug,
	output bcrypt_pkg::word_t    dout,
	input  logic                 rd_en,
	output logic                 empty,
	output logic                 src_done
);

	import bcrypt_pkg::*;

	localparam int IDX_W = $clog2(KEY_LEN);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(KEY_LEN - 1);
	localparam p_addr_t LAST_WORD = p_addr_t'(P_WORDS - 1);

	expand_state_t    state;
	logic [IDX_W-1:0] byte_idx;
	logic [1:0]       byte_cnt;
	p_addr_t          word_cnt;
	key_byte_t        cur_byte;
	word_t            fill;

	// the byte is picked out of the stored key in place, no copy of it is kept
	assign cur_byte = din[8*byte_idx +: 8];

	// normal mode fills only the low byte. In bug mode the sign-extended byte
	// lands on all 32 bits, as the old 2x variant did
	assign fill = sign_extension_bug ? {{24{cur_byte[7]}}, cur_byte}
		: {24'd0, cur_byte};

	// word assembly, first byte ends up in the top position
	always_ff @(posedge CLK) begin
		if (state == ST_INPUT) begin
			dout <= {dout[23:0], 8'h00} | fill;
		end
	end

	//////////////////////////////
	// FSM
	//////////////////////////////

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state    <= ST_IDLE;
			byte_idx <= '0;
			byte_cnt <= '0;
			word_cnt <= '0;
			empty    <= 1'b1;
			src_done <= 1'b0;
		end else begin
			src_done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (data_valid) begin
						state <= ST_WAIT1;
					end
				end

				ST_WAIT1: state <= ST_WAIT2;

				ST_WAIT2: state <= ST_INPUT;

				ST_INPUT: begin
					// the key cycles after its NUL or after its last byte
					if (cur_byte == 8'h00 || byte_idx == LAST_IDX) begin
						byte_idx <= '0;
					end else begin
						byte_idx <= byte_idx + 1'b1;
					end

					byte_cnt <= byte_cnt + 1'b1;
					if (byte_cnt == 2'd3) begin
						empty <= 1'b0;
						state <= ST_OUTPUT;
					end else begin
						state <= ST_WAIT1;
					end
				end

				// without rd_en the word and the state simply stay put
				ST_OUTPUT: begin
					if (rd_en) begin
						empty <= 1'b1;
						if (word_cnt == LAST_WORD) begin
							word_cnt <= '0;
							state    <= ST_READ_SRC;
						end else begin
							word_cnt <= word_cnt + 1'b1;
							state    <= ST_WAIT1;
						end
					end
				end

				// key fully consumed, hand it back to the register block
				ST_READ_SRC: begin
					byte_idx <= '0;
					src_done <= 1'b1;
					state    <= ST_IDLE;
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

//--- design/bcrypt_p_xor.sv
`timescale 1ns/1ps

module bcrypt_p_xor (
	input  logic                CLK,
	input  logic                arst_n,
	input  bcrypt_pkg::word_t   din,
	input  logic                empty,
	output logic                rd_en,
	input  bcrypt_pkg::p_addr_t p_rd_addr,
	output bcrypt_pkg::word_t   p_rd_data,
	output logic                done
);

	import bcrypt_pkg::*;

	localparam p_addr_t LAST_WORD = p_addr_t'(P_WORDS - 1);

	word_t   p_mem [P_WORDS];
	p_addr_t wr_idx;
	logic    last_store;

	// every word is taken the cycle it shows up, so the expander never stalls
	assign rd_en = !empty;

	//////////////////////////////
	// P-array store
	//////////////////////////////

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < P_WORDS; i++) begin
				p_mem[i] <= '0;
			end
			wr_idx     <= '0;
			last_store <= 1'b0;
			done       <= 1'b0;
		end else begin
			// done trails the final store by one cycle
			last_store <= rd_en && (wr_idx == LAST_WORD);
			done       <= last_store;

			if (rd_en) begin
				p_mem[wr_idx] <= din ^ P_INIT[wr_idx];
				if (wr_idx == LAST_WORD) begin
					wr_idx <= '0;
				end else begin
					wr_idx <= wr_idx + 1'b1;
				end
			end
		end
	end

	// host read port, addresses past the array read as zero
	assign p_rd_data = (p_rd_addr <= LAST_WORD) ? p_mem[p_rd_addr] : '0;

endmodule

//--- design/bcrypt_key_setup.sv
`timescale 1ns/1ps

module bcrypt_key_setup #(
	parameter int KEY_LEN = 72
) (
	input  logic                       CLK,
	input  logic                       arst_n,
	input  logic                       key_wr,
	input  logic [$clog2(KEY_LEN)-1:0] key_addr,
	input  bcrypt_pkg::key_byte_t      key_byte,
	input  logic                       mode_wr,
	input  logic                       mode,
	input  logic                       start,
	output logic                       busy,
	input  bcrypt_pkg::p_addr_t        p_rd_addr,
	output bcrypt_pkg::word_t          p_rd_data,
	output logic                       done
);

	import bcrypt_pkg::*;

	logic [8*KEY_LEN-1:0] key;
	logic                 sign_extension_bug;
	logic                 data_valid;
	logic                 src_done;
	word_t                ek_word;
	logic                 ek_empty;
	logic                 ek_rd_en;

	bcrypt_key_regs #(
		.KEY_LEN(KEY_LEN)
	) u_key_regs (
		.CLK               (CLK),
		.arst_n            (arst_n),
		.key_wr            (key_wr),
		.key_addr          (key_addr),
		.key_byte          (key_byte),
		.mode_wr           (mode_wr),
		.mode              (mode),
		.start             (start),
		.key               (key),
		.sign_extension_bug(sign_extension_bug),
		.data_valid        (data_valid),
		.src_done          (src_done),
		.busy              (busy)
	);

	bcrypt_expand_key #(
		.KEY_LEN(KEY_LEN)
	) u_expand_key (
		.CLK               (CLK),
		.arst_n            (arst_n),
		.din               (key),
		.data_valid        (data_valid),
		.sign_extension_bug(sign_extension_bug),
		.dout              (ek_word),
		.rd_en             (ek_rd_en),
		.empty             (ek_empty),
		.src_done          (src_done)
	);

	bcrypt_p_xor u_p_xor (
		.CLK      (CLK),
		.arst_n   (arst_n),
		.din      (ek_word),
		.empty    (ek_empty),
		.rd_en    (ek_rd_en),
		.p_rd_addr(p_rd_addr),
		.p_rd_data(p_rd_data),
		.done     (done)
	);

endmodule

//--- test/tb_key_vectors.svh
localparam int KIND_ASCII  = 0;
localparam int KIND_HIGH   = 1;
localparam int KIND_RANDOM = 2;

localparam int COL_KIND  = 0;
localparam int COL_LEN   = 1;
localparam int COL_MODE  = 2;
localparam int COL_PROBE = 3;

localparam int N_ROWS = 8;

// each row describes one run of the key setup. A row holds the key kind,
// the number of key bytes in front of the NUL, the mode bit and a flag
// that makes the testbench poke the registers while busy is high
localparam int VECTORS [N_ROWS][4] = '{
	// a short lower case key in normal mode
	'{KIND_ASCII,   8, 0, 0},
	// bytes of 0x80 and above in bug mode, then the same key in normal mode
	'{KIND_HIGH,    5, 1, 0},
	'{KIND_HIGH,    5, 0, 0},
	// a length of 72 puts no NUL at the end, so an ASCII key wraps after byte 71
	'{KIND_ASCII,  72, 0, 0},
	'{KIND_RANDOM, 72, 1, 0},
	// host traffic while the run is in flight
	'{KIND_RANDOM, 20, 0, 1},
	'{KIND_HIGH,    3, 1, 1},
	// with an empty key every byte the expander takes is the NUL
	'{KIND_ASCII,   0, 1, 0}
};

//--- test/tb_key_setup.sv
`timescale 1ns/1ps

module tb_key_setup;

	import bcrypt_pkg::*;

	`include "tb_key_vectors.svh"

	localparam int KEY_LEN     = 72;
	localparam int ADDR_W      = $clog2(KEY_LEN);
	localparam int SEED        = 70564;
	// key load, one run of about 240 cycles and the read back fit well inside this
	localparam int ROW_CYCLES  = 400;
	localparam int CYCLE_LIMIT = N_ROWS * ROW_CYCLES + 100;

	logic              CLK;
	logic              arst_n;
	logic              key_wr;
	logic [ADDR_W-1:0] key_addr;
	key_byte_t         key_byte;
	logic              mode_wr;
	logic              mode;
	logic              start;
	logic              busy;
	p_addr_t           p_rd_addr;
	word_t             p_rd_data;
	logic              done;

	key_byte_t key_img [KEY_LEN];
	word_t     exp_p [P_WORDS];
	int        cycle_cnt;
	int        done_total;

	bcrypt_key_setup #(
		.KEY_LEN(KEY_LEN)
	) u_bcrypt_key_setup (
		.CLK      (CLK),
		.arst_n   (arst_n),
		.key_wr   (key_wr),
		.key_addr (key_addr),
		.key_byte (key_byte),
		.mode_wr  (mode_wr),
		.mode     (mode),
		.start    (start),
		.busy     (busy),
		.p_rd_addr(p_rd_addr),
		.p_rd_data(p_rd_data),
		.done     (done)
	);

	initial CLK = 1'b0;
	always #2 CLK = ~CLK;

	//////////////////////////////
	// watchdog and done counter
	//////////////////////////////

	always @(posedge CLK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (done) begin
			done_total <= done_total + 1;
		end
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Error at %0t: timeout, the run did not finish in %0d cycles",
				$time, CYCLE_LIMIT);
			$display("STATUS: FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic fail_check(input string msg);
		$display("Error at %0t: %s", $time, msg);
		$display("STATUS: FAIL");
		$fatal(1, "check failed");
	endtask

	//////////////////////////////
	// key patterns and model
	//////////////////////////////

	function automatic key_byte_t pattern_byte(input int kind, input int idx);
		case (kind)
			KIND_ASCII: return 8'h61 + 8'(idx % 26);
			KIND_HIGH:  return 8'h80 | 8'((idx * 29 + 71) % 128);
			default:    return 8'($urandom);
		endcase
	endfunction

	task automatic make_key(input int kind, input int len);
		for (int i = 0; i < KEY_LEN; i++) begin
			key_img[i] = (i == len) ? 8'h00 : pattern_byte(kind, i);
		end
	endtask

	// the key cycles after a NUL or after its last byte, four bytes to a word with
	// the first one on top, and bug mode ORs the sign-extended byte over the word
	task automatic build_expected(input logic bug);
		int        j;
		word_t     w;
		key_byte_t b;
		j = 0;
		for (int k = 0; k < P_WORDS; k++) begin
			w = '0;
			for (int n = 0; n < 4; n++) begin
				b = key_img[j];
				w = (w << 8) | (bug ? {{24{b[7]}}, b} : {24'h0, b});
				j = (b == 8'h00 || j == KEY_LEN - 1) ? 0 : j + 1;
			end
			exp_p[k] = w ^ P_INIT[k];
		end
	endtask

	//////////////////////////////
	// host side tasks
	//////////////////////////////

	task automatic load_key();
		for (int i = 0; i < KEY_LEN; i++) begin
			key_wr   <= 1'b1;
			key_addr <= ADDR_W'(i);
			key_byte <= key_img[i];
			@(posedge CLK);
		end
		key_wr <= 1'b0;
	endtask

	task automatic set_mode(input logic m);
		mode_wr <= 1'b1;
		mode    <= m;
		@(posedge CLK);
		mode_wr <= 1'b0;
	endtask

	task automatic pulse_start();
		start <= 1'b1;
		@(posedge CLK);
		start <= 1'b0;
		@(posedge CLK);
		assert (busy == 1'b1) else fail_check("busy did not rise after start");
	endtask

	// none of this may reach the registers while busy is high
	task automatic poke_while_busy(input logic m);
		key_wr   <= 1'b1;
		key_addr <= '0;
		key_byte <= ~key_img[0];
		@(posedge CLK);
		key_wr  <= 1'b0;
		mode_wr <= 1'b1;
		mode    <= ~m;
		@(posedge CLK);
		mode_wr <= 1'b0;
		start   <= 1'b1;
		@(posedge CLK);
		start <= 1'b0;
	endtask

	task automatic read_p_array(input int row);
		for (int a = 0; a < P_WORDS; a++) begin
			p_rd_addr <= p_addr_t'(a);
			@(posedge CLK);
			assert (p_rd_data == exp_p[a]) else fail_check($sformatf(
				"row %0d P word %0d reads %08h, expected %08h",
				row, a, p_rd_data, exp_p[a]));
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		int done_before;
		arst_n    = 1'b0;
		key_wr    = 1'b0;
		key_addr  = '0;
		key_byte  = '0;
		mode_wr   = 1'b0;
		mode      = 1'b0;
		start     = 1'b0;
		p_rd_addr = '0;
		cycle_cnt  = 0;
		done_total = 0;
		void'($urandom(SEED));

		repeat (8) @(posedge CLK);
		arst_n <= 1'b1;
		@(posedge CLK);
		assert (busy == 1'b0 && done == 1'b0) else fail_check("busy or done set after reset");
		for (int k = 0; k < P_WORDS; k++) begin
			exp_p[k] = '0;
		end
		read_p_array(-1);

		for (int r = 0; r < N_ROWS; r++) begin
			make_key(VECTORS[r][COL_KIND], VECTORS[r][COL_LEN]);
			build_expected(VECTORS[r][COL_MODE] != 0);
			load_key();
			set_mode(VECTORS[r][COL_MODE] != 0);
			done_before = done_total;
			pulse_start();
			if (VECTORS[r][COL_PROBE] != 0) begin
				poke_while_busy(VECTORS[r][COL_MODE] != 0);
			end
			while (done !== 1'b1) begin
				@(posedge CLK);
			end
			@(posedge CLK);
			assert (busy == 1'b0) else fail_check($sformatf("row %0d busy still high", r));
			read_p_array(r);
			assert (done_total - done_before == 1) else fail_check($sformatf(
				"row %0d saw %0d done pulses, expected 1", r, done_total - done_before));
		end

		assert (done_total == N_ROWS) else fail_check($sformatf(
			"%0d done pulses in total, expected %0d", done_total, N_ROWS));
		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- all.f
design/bcrypt_pkg.sv
design/bcrypt_key_regs.sv
design/bcrypt_expand_key.sv
design/bcrypt_p_xor.sv
design/bcrypt_key_setup.sv
+incdir+test
test/tb_key_setup.sv

//--- run.sh
#!/bin/sh
# build the key setup testbench with Verilator, run it and scan the log for a failure
rm -rf obj_dir build.log sim.log
verilator --binary -Wno-fatal --top-module tb_key_setup -f all.f -o tb_key_setup \
	> build.log 2>&1 \
	&& ./obj_dir/tb_key_setup > sim.log 2>&1 \
	|| echo "STATUS: FAIL" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log \
	&& { echo "run.sh: simulation failed, see build.log and sim.log"; exit 1; } \
	|| echo "run.sh: simulation passed"
